// ==== rtl/core_pkg.sv ====
package core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // major opcodes of the RV32I subset
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [1:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    EX_IDLE,
    EX_RUN,
    EX_MEM,
    EX_HALT
  } exec_state_e;

  typedef enum logic [1:0] {
    F_IDLE,
    F_WAIT,
    F_FULL,
    F_DROP
  } fetch_state_e;

  typedef enum logic [1:0] {
    OWN_NONE,
    OWN_FETCH,
    OWN_LSU
  } owner_e;

  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  localparam word_t INSTR_EBREAK = 32'h0010_0073;

endpackage

// ==== rtl/mem_port_if.sv ====
`timescale 1ns/1ps

interface mem_port_if;

  logic            req_valid;
  logic            req_ready;
  logic            write;
  core_pkg::word_t addr;
  core_pkg::word_t wdata;
  logic            rsp_valid;
  core_pkg::word_t rdata;

  modport requester (
    output req_valid, write, addr, wdata,
    input  req_ready, rsp_valid, rdata
  );

  modport arbiter (
    input  req_valid, write, addr, wdata,
    output req_ready, rsp_valid, rdata
  );

endinterface

// ==== rtl/fetch_if.sv ====
`timescale 1ns/1ps

interface fetch_if;

  logic            valid;
  core_pkg::word_t pc;
  core_pkg::word_t instr;
  logic            ready;
  logic            redirect;
  core_pkg::word_t target;

  modport fetch (
    output valid, pc, instr,
    input  ready, redirect, target
  );

  modport execute (
    input  valid, pc, instr,
    output ready, redirect, target
  );

endinterface

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit #(
  parameter core_pkg::word_t RESET_PC = 32'h3000_0000
) (
  input  logic           clock,
  input  logic           reset,
  fetch_if.fetch         fetch_bus,
  mem_port_if.requester  mem_bus
);

  core_pkg::fetch_state_e state_q;
  core_pkg::word_t        pc_q;
  core_pkg::word_t        rsp_pc_q;
  core_pkg::word_t        buf_instr_q;
  core_pkg::word_t        buf_pc_q;
  core_pkg::word_t        target_q;
  logic                   redir_pend_q;
  logic                   live_q;
  logic                   stop_q;
  logic                   drain;
  logic                   issue;
  logic                   accepted;

  assign drain    = (state_q == core_pkg::F_FULL) && fetch_bus.ready;
  // never prefetch past an ebreak
  assign issue    = live_q && !stop_q &&
                    ((state_q == core_pkg::F_IDLE) ||
                     (drain && buf_instr_q != core_pkg::INSTR_EBREAK));
  assign accepted = issue && mem_bus.req_ready;

  assign mem_bus.req_valid = issue;
  assign mem_bus.write     = 1'b0;
  assign mem_bus.addr      = pc_q;
  assign mem_bus.wdata     = '0;

  assign fetch_bus.valid = (state_q == core_pkg::F_FULL);
  assign fetch_bus.pc    = buf_pc_q;
  assign fetch_bus.instr = buf_instr_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q      <= core_pkg::F_IDLE;
      pc_q         <= RESET_PC;
      redir_pend_q <= 1'b0;
      live_q       <= 1'b0;
      stop_q       <= 1'b0;
    end else begin
      live_q <= 1'b1;
      if (accepted) begin
        rsp_pc_q <= pc_q;
      end
      case (state_q)
        core_pkg::F_IDLE: begin
          if (accepted) begin
            if (fetch_bus.redirect) begin
              pc_q    <= fetch_bus.target;
              state_q <= core_pkg::F_DROP;
            end else if (redir_pend_q) begin
              pc_q         <= target_q;
              redir_pend_q <= 1'b0;
              state_q      <= core_pkg::F_DROP;
            end else begin
              pc_q    <= pc_q + 32'd4;
              state_q <= core_pkg::F_WAIT;
            end
          end else if (fetch_bus.redirect) begin
            // keep the stalled read stable and apply the target once it is taken
            target_q     <= fetch_bus.target;
            redir_pend_q <= 1'b1;
          end
        end
        core_pkg::F_WAIT: begin
          if (fetch_bus.redirect) begin
            pc_q    <= fetch_bus.target;
            state_q <= mem_bus.rsp_valid ? core_pkg::F_IDLE : core_pkg::F_DROP;
          end else if (mem_bus.rsp_valid) begin
            buf_instr_q <= mem_bus.rdata;
            buf_pc_q    <= rsp_pc_q;
            state_q     <= core_pkg::F_FULL;
          end
        end
        core_pkg::F_FULL: begin
          if (fetch_bus.redirect) begin
            pc_q    <= fetch_bus.target;
            state_q <= core_pkg::F_IDLE;
          end else if (drain) begin
            if (buf_instr_q == core_pkg::INSTR_EBREAK) begin
              stop_q <= 1'b1;
            end
            if (accepted) begin
              pc_q    <= pc_q + 32'd4;
              state_q <= core_pkg::F_WAIT;
            end else begin
              state_q <= core_pkg::F_IDLE;
            end
          end
        end
        default: begin
          // stale response is thrown away
          if (mem_bus.rsp_valid) begin
            state_q <= core_pkg::F_IDLE;
          end
        end
      endcase
    end
  end

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
  input  logic                clock,
  input  core_pkg::reg_addr_t rs1_addr_i,
  input  core_pkg::reg_addr_t rs2_addr_i,
  output core_pkg::word_t     rs1_data_o,
  output core_pkg::word_t     rs2_data_o,
  input  logic                we_i,
  input  core_pkg::reg_addr_t rd_addr_i,
  input  core_pkg::word_t     rd_data_i
);

  core_pkg::word_t regs [0:31];

  // x0 is hardwired to zero
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

  always_ff @(posedge clock) begin
    if (we_i && rd_addr_i != '0) begin
      regs[rd_addr_i] <= rd_data_i;
    end
  end

endmodule

// ==== rtl/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
  input  logic                clock,
  input  logic                reset,
  fetch_if.execute            fetch_bus,
  output core_pkg::reg_addr_t rs1_addr_o,
  output core_pkg::reg_addr_t rs2_addr_o,
  input  core_pkg::word_t     rs1_data_i,
  input  core_pkg::word_t     rs2_data_i,
  output logic                we_o,
  output core_pkg::reg_addr_t rd_addr_o,
  output core_pkg::word_t     rd_data_o,
  output logic                start_o,
  output logic                write_o,
  output core_pkg::word_t     addr_o,
  output core_pkg::word_t     store_data_o,
  input  logic                done_i,
  input  core_pkg::word_t     load_data_i,
  output logic                halt_o
);

  core_pkg::exec_state_e state_q;
  core_pkg::word_t       instr_q;
  core_pkg::word_t       pc_q;
  core_pkg::opcode_e     opcode;
  core_pkg::alu_op_e     alu_op;
  logic [2:0]            funct3;
  core_pkg::word_t       imm;
  core_pkg::word_t       alu_b;
  core_pkg::word_t       alu_y;
  logic                  writes_rd;
  logic                  is_mem;
  logic                  is_jump;
  logic                  is_ebreak;
  logic                  regs_eq;
  logic                  running;

  assign opcode     = core_pkg::opcode_e'(instr_q[6:0]);
  assign funct3     = instr_q[14:12];
  assign rs1_addr_o = instr_q[19:15];
  assign rs2_addr_o = instr_q[24:20];
  assign rd_addr_o  = instr_q[11:7];
  assign regs_eq    = (rs1_data_i == rs2_data_i);
  assign running    = (state_q == core_pkg::EX_RUN);

  always_comb begin
    imm       = '0;
    alu_op    = core_pkg::ALU_ADD;
    writes_rd = 1'b0;
    is_mem    = 1'b0;
    is_jump   = 1'b0;
    is_ebreak = 1'b0;
    case (opcode)
      core_pkg::OP_LUI: begin
        imm       = {instr_q[31:12], 12'b0};
        alu_op    = core_pkg::ALU_PASS_B;
        writes_rd = 1'b1;
      end
      core_pkg::OP_IMM: begin
        imm       = {{20{instr_q[31]}}, instr_q[31:20]};
        writes_rd = (funct3 == core_pkg::F3_ADD);
      end
      core_pkg::OP_REG: begin
        alu_op    = instr_q[30] ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
        writes_rd = (funct3 == core_pkg::F3_ADD);
      end
      core_pkg::OP_LOAD: begin
        imm    = {{20{instr_q[31]}}, instr_q[31:20]};
        is_mem = 1'b1;
      end
      core_pkg::OP_STORE: begin
        imm    = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
        is_mem = 1'b1;
      end
      core_pkg::OP_BRANCH: begin
        imm     = {{19{instr_q[31]}}, instr_q[31], instr_q[7], instr_q[30:25],
                   instr_q[11:8], 1'b0};
        is_jump = (funct3 == core_pkg::F3_BEQ && regs_eq) ||
                  (funct3 == core_pkg::F3_BNE && !regs_eq);
      end
      core_pkg::OP_JAL: begin
        imm       = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12], instr_q[20],
                     instr_q[30:21], 1'b0};
        writes_rd = 1'b1;
        is_jump   = 1'b1;
      end
      core_pkg::OP_SYSTEM: begin
        is_ebreak = (instr_q == core_pkg::INSTR_EBREAK);
      end
      default: begin
      end
    endcase
  end

  assign alu_b = (opcode == core_pkg::OP_REG) ? rs2_data_i : imm;

  always_comb begin
    case (alu_op)
      core_pkg::ALU_SUB:    alu_y = rs1_data_i - alu_b;
      core_pkg::ALU_PASS_B: alu_y = alu_b;
      default:              alu_y = rs1_data_i + alu_b;
    endcase
  end

  // load data comes back combinationally with done
  always_comb begin
    if (state_q == core_pkg::EX_MEM) begin
      rd_data_o = load_data_i;
    end else if (opcode == core_pkg::OP_JAL) begin
      rd_data_o = pc_q + 32'd4;
    end else begin
      rd_data_o = alu_y;
    end
  end

  assign we_o = (running && writes_rd) ||
                (state_q == core_pkg::EX_MEM && done_i && opcode == core_pkg::OP_LOAD);

  assign start_o      = running && is_mem;
  assign write_o      = (opcode == core_pkg::OP_STORE);
  assign addr_o       = alu_y;
  assign store_data_o = rs2_data_i;

  assign fetch_bus.ready    = (state_q == core_pkg::EX_IDLE);
  assign fetch_bus.redirect = running && is_jump;
  assign fetch_bus.target   = pc_q + imm;

  assign halt_o = (state_q == core_pkg::EX_HALT);

  always_ff @(posedge clock) begin
    if (fetch_bus.valid && fetch_bus.ready) begin
      instr_q <= fetch_bus.instr;
      pc_q    <= fetch_bus.pc;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= core_pkg::EX_IDLE;
    end else begin
      case (state_q)
        core_pkg::EX_IDLE: begin
          if (fetch_bus.valid) begin
            state_q <= core_pkg::EX_RUN;
          end
        end
        core_pkg::EX_RUN: begin
          if (is_mem) begin
            state_q <= core_pkg::EX_MEM;
          end else if (is_ebreak) begin
            state_q <= core_pkg::EX_HALT;
          end else begin
            state_q <= core_pkg::EX_IDLE;
          end
        end
        core_pkg::EX_MEM: begin
          if (done_i) begin
            state_q <= core_pkg::EX_IDLE;
          end
        end
        default: state_q <= core_pkg::EX_HALT;
      endcase
    end
  end

endmodule

// ==== rtl/load_store_unit.sv ====
`timescale 1ns/1ps

module load_store_unit (
  input  logic            clock,
  input  logic            reset,
  input  logic            start_i,
  input  logic            write_i,
  input  core_pkg::word_t addr_i,
  input  core_pkg::word_t store_data_i,
  output logic            done_o,
  output core_pkg::word_t load_data_o,
  mem_port_if.requester   mem_bus
);

  logic            pend_q;
  logic            wait_q;
  logic            write_q;
  core_pkg::word_t addr_q;
  core_pkg::word_t data_q;

  // request held stable until the arbiter takes it
  assign mem_bus.req_valid = pend_q;
  assign mem_bus.write     = write_q;
  assign mem_bus.addr      = addr_q;
  assign mem_bus.wdata     = data_q;

  assign done_o      = wait_q && mem_bus.rsp_valid;
  assign load_data_o = mem_bus.rdata;

  always_ff @(posedge clock) begin
    if (start_i) begin
      write_q <= write_i;
      addr_q  <= addr_i;
      data_q  <= store_data_i;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pend_q <= 1'b0;
      wait_q <= 1'b0;
    end else if (start_i) begin
      pend_q <= 1'b1;
    end else if (pend_q && mem_bus.req_ready) begin
      pend_q <= 1'b0;
      wait_q <= 1'b1;
    end else if (done_o) begin
      wait_q <= 1'b0;
    end
  end

endmodule

// ==== rtl/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
  input  logic            clock,
  input  logic            reset,
  mem_port_if.arbiter     fetch_bus,
  mem_port_if.arbiter     lsu_bus,
  output logic            mem_req_valid_o,
  input  logic            mem_req_ready_i,
  output logic            mem_write_o,
  output core_pkg::word_t mem_addr_o,
  output core_pkg::word_t mem_wdata_o,
  input  logic            mem_rsp_valid_i,
  input  core_pkg::word_t mem_rdata_i
);

  core_pkg::owner_e owner_q;
  core_pkg::owner_e hold_q;
  logic             idle;
  logic             sel_lsu;
  logic             grant_lsu;
  logic             grant_fetch;
  logic             accepted;

  assign idle = (owner_q == core_pkg::OWN_NONE);

  // a stalled grant is kept so the port stays stable
  assign sel_lsu = (hold_q == core_pkg::OWN_LSU) ||
                   (hold_q == core_pkg::OWN_NONE && lsu_bus.req_valid);

  assign grant_lsu   = idle && sel_lsu && lsu_bus.req_valid;
  assign grant_fetch = idle && !sel_lsu && fetch_bus.req_valid;
  assign accepted    = mem_req_valid_o && mem_req_ready_i;

  assign mem_req_valid_o = grant_lsu || grant_fetch;
  assign mem_write_o     = grant_lsu ? lsu_bus.write : fetch_bus.write;
  assign mem_addr_o      = grant_lsu ? lsu_bus.addr : fetch_bus.addr;
  assign mem_wdata_o     = grant_lsu ? lsu_bus.wdata : fetch_bus.wdata;

  assign lsu_bus.req_ready   = grant_lsu && mem_req_ready_i;
  assign fetch_bus.req_ready = grant_fetch && mem_req_ready_i;

  assign lsu_bus.rsp_valid   = mem_rsp_valid_i && owner_q == core_pkg::OWN_LSU;
  assign fetch_bus.rsp_valid = mem_rsp_valid_i && owner_q == core_pkg::OWN_FETCH;
  assign lsu_bus.rdata       = mem_rdata_i;
  assign fetch_bus.rdata     = mem_rdata_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      owner_q <= core_pkg::OWN_NONE;
      hold_q  <= core_pkg::OWN_NONE;
    end else begin
      if (accepted) begin
        owner_q <= grant_lsu ? core_pkg::OWN_LSU : core_pkg::OWN_FETCH;
        hold_q  <= core_pkg::OWN_NONE;
      end else if (mem_req_valid_o) begin
        hold_q <= grant_lsu ? core_pkg::OWN_LSU : core_pkg::OWN_FETCH;
      end
      if (mem_rsp_valid_i) begin
        owner_q <= core_pkg::OWN_NONE;
      end
    end
  end

endmodule

// ==== rtl/core_top.sv ====
`timescale 1ns/1ps

module core_top #(
  parameter core_pkg::word_t RESET_PC = 32'h3000_0000
) (
  input  logic            clock,
  input  logic            reset,
  output logic            mem_req_valid_o,
  input  logic            mem_req_ready_i,
  output logic            mem_write_o,
  output core_pkg::word_t mem_addr_o,
  output core_pkg::word_t mem_wdata_o,
  input  logic            mem_rsp_valid_i,
  input  core_pkg::word_t mem_rdata_i,
  output logic            halt_o
);

  mem_port_if fetch_mem ();
  mem_port_if lsu_mem ();
  fetch_if    fetch_bus ();

  core_pkg::reg_addr_t rs1_addr;
  core_pkg::reg_addr_t rs2_addr;
  core_pkg::reg_addr_t rd_addr;
  core_pkg::word_t     rs1_data;
  core_pkg::word_t     rs2_data;
  core_pkg::word_t     rd_data;
  logic                rd_we;
  logic                ls_start;
  logic                ls_write;
  logic                ls_done;
  core_pkg::word_t     ls_addr;
  core_pkg::word_t     ls_store_data;
  core_pkg::word_t     ls_load_data;

  fetch_unit #(
    .RESET_PC (RESET_PC)
  ) u_fetch (
    .clock     (clock),
    .reset     (reset),
    .fetch_bus (fetch_bus.fetch),
    .mem_bus   (fetch_mem.requester)
  );

  execute_unit u_execute (
    .clock        (clock),
    .reset        (reset),
    .fetch_bus    (fetch_bus.execute),
    .rs1_addr_o   (rs1_addr),
    .rs2_addr_o   (rs2_addr),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .we_o         (rd_we),
    .rd_addr_o    (rd_addr),
    .rd_data_o    (rd_data),
    .start_o      (ls_start),
    .write_o      (ls_write),
    .addr_o       (ls_addr),
    .store_data_o (ls_store_data),
    .done_i       (ls_done),
    .load_data_i  (ls_load_data),
    .halt_o       (halt_o)
  );

  reg_file u_regs (
    .clock      (clock),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .we_i       (rd_we),
    .rd_addr_i  (rd_addr),
    .rd_data_i  (rd_data)
  );

  load_store_unit u_lsu (
    .clock        (clock),
    .reset        (reset),
    .start_i      (ls_start),
    .write_i      (ls_write),
    .addr_i       (ls_addr),
    .store_data_i (ls_store_data),
    .done_o       (ls_done),
    .load_data_o  (ls_load_data),
    .mem_bus      (lsu_mem.requester)
  );

  mem_arbiter u_arbiter (
    .clock           (clock),
    .reset           (reset),
    .fetch_bus       (fetch_mem.arbiter),
    .lsu_bus         (lsu_mem.arbiter),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_write_o     (mem_write_o),
    .mem_addr_o      (mem_addr_o),
    .mem_wdata_o     (mem_wdata_o),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rdata_i     (mem_rdata_i)
  );

endmodule

// ==== tb/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
  parameter int HALF_PERIOD  = 20,
  parameter int RESET_CYCLES = 5
) (
  output logic clock_o,
  output logic reset_o
);

  initial begin
    clock_o = 1'b0;
    forever #(HALF_PERIOD) clock_o = ~clock_o;
  end

  // power-on reset released just after an edge
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock_o);
    #1;
    reset_o = 1'b0;
  end

endmodule

// ==== tb/core_tb.sv ====
`timescale 1ns/1ps

module core_tb;

  typedef core_pkg::word_t word_t;
  typedef logic [4:0] reg_t;

  localparam word_t BOOT_PC         = 32'h3000_0000;
  localparam word_t EBREAK          = 32'h0010_0073;
  localparam int    NUM_TESTS       = 6;
  localparam int    CYCLES_PER_TEST = 400;

  logic  clock;
  logic  por_reset;
  logic  test_reset;
  logic  reset;
  logic  mem_req_valid;
  logic  mem_req_ready;
  logic  mem_write;
  word_t mem_addr;
  word_t mem_wdata;
  logic  mem_rsp_valid;
  word_t mem_rdata;
  logic  halt;

  word_t       mem [0:1023];
  word_t       prog[$];
  word_t       exp_addr[$];
  word_t       exp_data[$];
  word_t       log_addr[$];
  word_t       log_data[$];
  int unsigned stall_pct;
  int          accept_count;
  logic        first_seen;
  word_t       first_addr;
  logic        first_write;

  assign reset = por_reset || test_reset;

  clock_gen u_clock (
    .clock_o (clock),
    .reset_o (por_reset)
  );

  core_top #(
    .RESET_PC (BOOT_PC)
  ) uut (
    .clock           (clock),
    .reset           (reset),
    .mem_req_valid_o (mem_req_valid),
    .mem_req_ready_i (mem_req_ready),
    .mem_write_o     (mem_write),
    .mem_addr_o      (mem_addr),
    .mem_wdata_o     (mem_wdata),
    .mem_rsp_valid_i (mem_rsp_valid),
    .mem_rdata_i     (mem_rdata),
    .halt_o          (halt)
  );

  // memory model samples at negedge and drives 1 ns after posedge
  initial begin
    int         delay;
    logic       pend;
    word_t      rsp_data;
    logic [9:0] idx;
    void'($urandom(32'h339c));
    pend          = 1'b0;
    delay         = 0;
    rsp_data      = '0;
    accept_count  = 0;
    first_seen    = 1'b0;
    mem_req_ready = 1'b0;
    mem_rsp_valid = 1'b0;
    mem_rdata     = '0;
    forever begin
      @(negedge clock);
      if (reset) begin
        pend       = 1'b0;
        first_seen = 1'b0;
      end else if (mem_req_valid && mem_req_ready) begin
        accept_count++;
        if (!first_seen) begin
          first_seen  = 1'b1;
          first_addr  = mem_addr;
          first_write = mem_write;
        end
        idx = mem_addr[11:2];
        if (mem_write) begin
          mem[idx] = mem_wdata;
          log_addr.push_back(mem_addr);
          log_data.push_back(mem_wdata);
        end
        rsp_data = mem[idx];
        pend     = 1'b1;
        delay    = $urandom % 4;
      end
      @(posedge clock);
      #1;
      mem_rsp_valid = 1'b0;
      if (pend) begin
        if (delay == 0) begin
          mem_rsp_valid = 1'b1;
          mem_rdata     = rsp_data;
          pend          = 1'b0;
        end else begin
          delay--;
        end
      end
      mem_req_ready = ($urandom % 100) >= stall_pct;
    end
  end

  initial begin
    repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clock);
    $display("Timeout: the tests did not finish within %0d clock cycles",
             NUM_TESTS * CYCLES_PER_TEST);
    $display("** FAIL **");
    $fatal(1, "watchdog expired");
  end

  task automatic check_value(input word_t actual, input word_t expected, input string what);
    if (actual !== expected) begin
      $display("ERR %0t: %s is %h, expected %h", $time, what, actual, expected);
      $display("** FAIL **");
      $fatal(1, "check failed");
    end
  endtask

  function automatic word_t sext12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  function automatic word_t enc_lui(input reg_t rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic word_t enc_addi(input reg_t rd, input reg_t rs1, input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic word_t enc_reg(input logic [6:0] f7, input reg_t rd, input reg_t rs1,
                                    input reg_t rs2);
    return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic word_t enc_lw(input reg_t rd, input reg_t rs1, input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, 7'b0000011};
  endfunction

  function automatic word_t enc_sw(input reg_t rs2, input reg_t rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t enc_branch(input logic [2:0] f3, input reg_t rs1, input reg_t rs2,
                                       input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic word_t enc_jal(input reg_t rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  task automatic new_program();
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
  endtask

  task automatic expect_write(input word_t addr, input word_t data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  // waits past the model's negedge update
  task automatic next_sample();
    @(negedge clock);
    #2;
  endtask

  task automatic start_reset();
    @(posedge clock);
    #1;
    test_reset = 1'b1;
    // addi x0,x0,index as a no-op fill
    for (int i = 0; i < 1024; i++) begin
      mem[i[9:0]] = {i[11:0], 20'h00013};
    end
    foreach (prog[i]) begin
      mem[i[9:0]] = prog[i];
    end
    log_addr.delete();
    log_data.delete();
  endtask

  task automatic release_reset();
    @(posedge clock);
    repeat (4) begin
      @(negedge clock);
      check_value(32'(mem_req_valid), 32'd0, "request valid in reset");
      check_value(32'(halt), 32'd0, "halt in reset");
    end
    @(posedge clock);
    #1;
    test_reset = 1'b0;
    @(negedge clock);
    check_value(32'(mem_req_valid), 32'd0, "request valid after reset");
    check_value(32'(halt), 32'd0, "halt after reset");
  endtask

  task automatic run_and_check();
    while (halt !== 1'b1) begin
      next_sample();
    end
    check_value(log_addr.size(), exp_addr.size(), "write count");
    foreach (exp_addr[i]) begin
      check_value(log_addr[i], exp_addr[i], "write address");
      check_value(log_data[i], exp_data[i], "write data");
    end
  endtask

  task automatic build_arith();
    word_t v2;
    word_t v3;
    new_program();
    prog.push_back(enc_lui(5'd1, 20'h30000));
    prog.push_back(enc_lui(5'd2, 20'h12345));
    prog.push_back(enc_addi(5'd2, 5'd2, 12'h678));
    prog.push_back(enc_addi(5'd3, 5'd0, 12'hffb));
    prog.push_back(enc_reg(7'h00, 5'd4, 5'd2, 5'd3));
    prog.push_back(enc_reg(7'h20, 5'd5, 5'd3, 5'd2));
    prog.push_back(enc_sw(5'd2, 5'd1, 12'h400));
    prog.push_back(enc_sw(5'd3, 5'd1, 12'h404));
    prog.push_back(enc_sw(5'd4, 5'd1, 12'h408));
    prog.push_back(enc_sw(5'd5, 5'd1, 12'h40c));
    prog.push_back(EBREAK);
    v2 = {20'h12345, 12'h000} + sext12(12'h678);
    v3 = sext12(12'hffb);
    expect_write(32'h3000_0400, v2);
    expect_write(32'h3000_0404, v3);
    expect_write(32'h3000_0408, v2 + v3);
    expect_write(32'h3000_040c, v3 - v2);
  endtask

  task automatic test_reset_state();
    new_program();
    prog.push_back(EBREAK);
    start_reset();
    release_reset();
    while (!first_seen) begin
      next_sample();
    end
    check_value(first_addr, BOOT_PC, "first request address");
    check_value(32'(first_write), 32'd0, "first request write");
    run_and_check();
  endtask

  task automatic test_arith();
    build_arith();
    start_reset();
    release_reset();
    run_and_check();
  endtask

  task automatic test_loads();
    word_t a;
    word_t b;
    a = 32'h1357_9bdf;
    b = 32'h0246_8ace;
    new_program();
    prog.push_back(enc_lui(5'd1, 20'h30000));
    prog.push_back(enc_lw(5'd2, 5'd1, 12'h500));
    prog.push_back(enc_lw(5'd3, 5'd1, 12'h504));
    prog.push_back(enc_reg(7'h00, 5'd4, 5'd2, 5'd3));
    prog.push_back(enc_reg(7'h00, 5'd0, 5'd2, 5'd3));
    prog.push_back(enc_sw(5'd4, 5'd1, 12'h410));
    prog.push_back(enc_sw(5'd0, 5'd1, 12'h414));
    prog.push_back(EBREAK);
    expect_write(32'h3000_0410, a + b);
    expect_write(32'h3000_0414, 32'd0);
    start_reset();
    mem[10'h140] = a;
    mem[10'h141] = b;
    release_reset();
    run_and_check();
  endtask

  task automatic test_control_flow();
    word_t jal_pc;
    new_program();
    prog.push_back(enc_lui(5'd1, 20'h30000));
    prog.push_back(enc_addi(5'd2, 5'd0, 12'h007));
    prog.push_back(enc_addi(5'd3, 5'd0, 12'h007));
    prog.push_back(enc_addi(5'd4, 5'd0, 12'h666));
    prog.push_back(enc_branch(3'b000, 5'd2, 5'd3, 13'd8));
    prog.push_back(enc_sw(5'd4, 5'd1, 12'h420));
    prog.push_back(enc_branch(3'b001, 5'd2, 5'd3, 13'd8));
    prog.push_back(enc_sw(5'd2, 5'd1, 12'h424));
    jal_pc = BOOT_PC + 32'(prog.size() * 4);
    prog.push_back(enc_jal(5'd5, 21'd8));
    prog.push_back(enc_sw(5'd4, 5'd1, 12'h428));
    prog.push_back(enc_sw(5'd5, 5'd1, 12'h42c));
    prog.push_back(EBREAK);
    expect_write(32'h3000_0424, 32'd7);
    expect_write(32'h3000_042c, jal_pc + 32'd4);
    start_reset();
    release_reset();
    run_and_check();
  endtask

  task automatic test_backpressure();
    stall_pct = 75;
    build_arith();
    start_reset();
    release_reset();
    run_and_check();
    stall_pct = 20;
  endtask

  task automatic test_ebreak();
    int count;
    new_program();
    prog.push_back(enc_addi(5'd2, 5'd0, 12'h001));
    prog.push_back(EBREAK);
    prog.push_back(enc_sw(5'd2, 5'd0, 12'h430));
    start_reset();
    release_reset();
    run_and_check();
    count = accept_count;
    repeat (20) begin
      next_sample();
    end
    check_value(accept_count, count, "requests after halt");
    check_value(32'(halt), 32'd1, "halt held");
  endtask

  initial begin
    test_reset = 1'b0;
    stall_pct  = 20;
    wait (por_reset === 1'b0);
    test_reset_state();
    test_arith();
    test_loads();
    test_control_flow();
    test_backpressure();
    test_ebreak();
    $display("** PASS **");
    $finish;
  end

endmodule

// ==== flist.f ====
rtl/core_pkg.sv
rtl/mem_port_if.sv
rtl/fetch_if.sv
rtl/fetch_unit.sv
rtl/reg_file.sv
rtl/execute_unit.sv
rtl/load_store_unit.sv
rtl/mem_arbiter.sv
rtl/core_top.sv
tb/clock_gen.sv
tb/core_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --timing
TOP       = core_tb
RTL_TOP   = core_top
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FLIST)
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)_sim
	./$(OBJ_DIR)/$(TOP)_sim > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
